//--- prog.hex
// one 32-bit instruction word per line, loaded from address 0
00500093
00700113
002081B3
40118233
0020F533
0020E5B3
00302423
00802283
00128313
00220463
06300393
0080046F
03700493
00A00893
00000073

//--- compile.f
rv_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
rv_core.sv
rv_core_properties.sv
rv_checker.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_rv_core.sv
// testbench for the five-stage core
// clock, reset, watchdog, table of expected register values
// read-out loop over the debug port after halt
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int clk_period   = 8;
  localparam int drive_delay  = 1;
  localparam int reset_cycles = 10;
  localparam int prog_len     = 15; // words in prog.hex
  localparam int n_rows       = 13;
  // run to halt, then two cycles per row plus the report
  localparam int watchdog_cycles = reset_cycles + 20 * prog_len + 100 + 2 * n_rows + 4;

  // {register index, expected value}
  localparam logic [36:0] check_table [n_rows] = '{
    {5'd0,  32'd0},  // x0 stays zero
    {5'd1,  32'd5},
    {5'd2,  32'd7},
    {5'd3,  32'd12}, // forwarded from both stages
    {5'd4,  32'd7},
    {5'd10, 32'd5},
    {5'd11, 32'd7},
    {5'd5,  32'd12}, // store then load
    {5'd6,  32'd13}, // load-use stall
    {5'd7,  32'd0},  // squashed by taken beq
    {5'd8,  32'd48}, // jal link
    {5'd9,  32'd0},  // skipped by jal
    {5'd17, 32'd10}
  };

  logic                  clk;
  logic                  reset;
  logic                  halted;
  logic                  check;
  logic                  report;
  logic [reg_addr_w-1:0] dbg_addr;
  logic [reg_addr_w-1:0] exp_addr;
  logic [xlen-1:0]       dbg_data;
  logic [xlen-1:0]       exp_val;
  int                    n_checks;
  int                    n_errors;

  rv_core u_rv_core (
    .clk(clk),
    .reset(reset),
    .halted(halted),
    .dbg_addr(dbg_addr),
    .dbg_data(dbg_data)
  );

  rv_checker u_checker (
    .clk(clk),
    .check(check),
    .report(report),
    .halted(halted),
    .exp_addr(exp_addr),
    .exp_val(exp_val),
    .dbg_data(dbg_data),
    .n_checks(n_checks),
    .n_errors(n_errors)
  );

  always #(clk_period / 2) clk = ~clk;

  // watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    if (!halted) begin
      $display("core never halted within %0d cycles", watchdog_cycles);
    end else begin
      $display("register read-out did not finish within %0d cycles", watchdog_cycles);
    end
    $display("Done: errors found");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    dbg_addr = '0;
    exp_addr = '0;
    exp_val  = '0;
    check    = 1'b0;
    report   = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    reset = 1'b0;

    wait (halted);
    $display("core halted at %0t", $time);

    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #(drive_delay);
      check    = 1'b0;
      dbg_addr = check_table[i][36:32];
      @(posedge clk);
      #(drive_delay);
      check    = 1'b1; // checker samples on the next edge
      exp_addr = check_table[i][36:32];
      exp_val  = check_table[i][31:0];
    end

    @(posedge clk);
    #(drive_delay);
    check  = 1'b0;
    report = 1'b1;
    @(posedge clk);
    #(drive_delay);
    report = 1'b0;

    if (n_errors == 0 && n_checks == n_rows) begin
      $display("Done: no errors");
    end else begin
      if (n_checks != n_rows) begin
        $display("only %0d of %0d register checks ran", n_checks, n_rows);
      end
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- rv_checker.sv
// result checker for the core testbench
// compares debug port reads with expected values, keeps counts
`timescale 1ns/1ps

module rv_checker (
  input  logic                          clk,
  input  logic                          check,
  input  logic                          report,
  input  logic                          halted,
  input  logic [rv_pkg::reg_addr_w-1:0] exp_addr,
  input  logic [rv_pkg::xlen-1:0]       exp_val,
  input  logic [rv_pkg::xlen-1:0]       dbg_data,
  output int                            n_checks,
  output int                            n_errors
);

  initial begin
    n_checks = 0;
    n_errors = 0;
  end

  // registers are frozen after halt, so dbg_data only moves with dbg_addr
  always @(posedge clk) begin
    if (check) begin
      n_checks = n_checks + 1;
      if (!halted) begin
        n_errors = n_errors + 1;
        $display("core is no longer halted during read-out of x%0d", exp_addr);
      end
      if (dbg_data !== exp_val) begin
        n_errors = n_errors + 1;
        $display("error at %0t: x%0d reads %h, expected %h",
                 $time, exp_addr, dbg_data, exp_val);
      end else begin
        $display("ok    x%0d = %h", exp_addr, dbg_data);
      end
    end
    if (report) begin
      $display("checks: %0d run, %0d failed", n_checks, n_errors);
    end
  end

endmodule

//--- rv_core_properties.sv
// concurrent assertions for rv_core, attached by bind
// reset value of halted, sticky halt, pc alignment, pc hold on stall
`timescale 1ns/1ps

module rv_core_properties (
  input logic                    clk,
  input logic                    reset,
  input logic                    halted,
  input logic                    stall,
  input logic                    redirect,
  input logic [rv_pkg::xlen-1:0] pc
);

  halted_low_in_reset: assert property (@(posedge clk) reset |=> !halted)
    else $error("halted is high while reset is applied");

  halted_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else $error("halted fell after it was set");

  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // a redirect wins over the stall in fetch
  pc_held_on_stall: assert property (@(posedge clk) disable iff (reset)
                                     (stall && !redirect) |=> $stable(pc))
    else $error("pc moved during a load-use stall");

endmodule

bind rv_core rv_core_properties u_props (
  .clk(clk),
  .reset(reset),
  .halted(halted),
  .stall(stall),
  .redirect(redirect),
  .pc(u_fetch.pc)
);

//--- rv_core.sv
// top level of the five-stage core
// connects fetch, decode, execute and mem/wb stages
`timescale 1ns/1ps

module rv_core (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         halted,
  input  logic [rv_pkg::reg_addr_w-1:0] dbg_addr,
  output logic [rv_pkg::xlen-1:0]       dbg_data
);
  import rv_pkg::*;

  // fetch side
  logic            stall, redirect;
  logic [xlen-1:0] redirect_pc, if_pc;
  inst_t           if_inst;

  // ID/EX
  logic                  id_ex_alu_src, id_ex_mem_read, id_ex_mem_write, id_ex_reg_write;
  logic                  id_ex_is_branch, id_ex_branch_ne, id_ex_is_jal, id_ex_is_jalr;
  logic                  id_ex_halt_req;
  logic [alu_sel_w-1:0]  id_ex_alu_sel;
  logic [1:0]            id_ex_wb_src;
  logic [xlen-1:0]       id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc;
  logic [reg_addr_w-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;

  // EX/MEM
  logic                  ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write, ex_mem_halt_req;
  logic [1:0]            ex_mem_wb_src;
  logic [xlen-1:0]       ex_mem_result, ex_mem_store_data, ex_mem_pc4;
  logic [reg_addr_w-1:0] ex_mem_rd;

  // writeback, back to regfile and forwarding
  logic                  wb_we;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;

  // port names match the nets above
  fetch_stage   u_fetch   (.*);
  decode_stage  u_decode  (.*);
  execute_stage u_execute (.*);
  mem_wb_stage  u_mem_wb  (.*);

endmodule

//--- mem_wb_stage.sv
// data memory, MEM/WB register, writeback mux
// sticky halt flag
`timescale 1ns/1ps

module mem_wb_stage (
  input  logic                          clk, reset,
  input  logic                          ex_mem_mem_read, ex_mem_mem_write,
  input  logic                          ex_mem_reg_write, ex_mem_halt_req,
  input  logic [1:0]                    ex_mem_wb_src,
  input  logic [rv_pkg::xlen-1:0]        ex_mem_result, ex_mem_store_data, ex_mem_pc4,
  input  logic [rv_pkg::reg_addr_w-1:0]  ex_mem_rd,
  output logic                          wb_we,
  output logic [rv_pkg::reg_addr_w-1:0]  wb_rd,
  output logic [rv_pkg::xlen-1:0]        wb_data,
  output logic                          halted
);
  import rv_pkg::*;

  logic [xlen-1:0]                 dmem [0:dmem_words-1];
  logic [$clog2(dmem_words)-1:0]   daddr;
  logic [xlen-1:0]                 load_data, mem_wb_alu, mem_wb_load, mem_wb_pc4;
  logic [1:0]                      mem_wb_wb_src;
  logic                            mem_wb_reg_write, mem_wb_halt_req;

  assign daddr     = ex_mem_result[$clog2(dmem_words)+1:2]; // word address
  assign load_data = ex_mem_mem_read ? dmem[daddr] : '0;

  always_ff @(posedge clk) begin
    if (ex_mem_mem_write && !halted) dmem[daddr] <= ex_mem_store_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb_reg_write <= 1'b0;
      mem_wb_halt_req  <= 1'b0;
      halted           <= 1'b0;
    end else if (!halted) begin
      mem_wb_reg_write <= ex_mem_reg_write;
      mem_wb_halt_req  <= ex_mem_halt_req;
      halted           <= mem_wb_halt_req; // once set, never cleared
    end
  end

  always_ff @(posedge clk) begin
    if (!halted) begin
      mem_wb_wb_src <= ex_mem_wb_src;
      mem_wb_alu    <= ex_mem_result;
      mem_wb_load   <= load_data;
      mem_wb_pc4    <= ex_mem_pc4;
      wb_rd         <= ex_mem_rd;
    end
  end

  always_comb begin
    case (mem_wb_wb_src)
      wb_mem:  wb_data = mem_wb_load;
      wb_pc4:  wb_data = mem_wb_pc4;
      default: wb_data = mem_wb_alu;
    endcase
  end

  assign wb_we = mem_wb_reg_write && !halted;

endmodule

//--- execute_stage.sv
// operand forwarding, alu, branch and jump resolution
// EX/MEM register
`timescale 1ns/1ps

module execute_stage (
  input  logic                          clk, reset, halted,
  input  logic                          id_ex_alu_src, id_ex_mem_read, id_ex_mem_write,
  input  logic                          id_ex_reg_write, id_ex_is_branch, id_ex_branch_ne,
  input  logic                          id_ex_is_jal, id_ex_is_jalr, id_ex_halt_req,
  input  logic [rv_pkg::alu_sel_w-1:0]   id_ex_alu_sel,
  input  logic [1:0]                    id_ex_wb_src,
  input  logic [rv_pkg::xlen-1:0]        id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc,
  input  logic [rv_pkg::reg_addr_w-1:0]  id_ex_rs1, id_ex_rs2, id_ex_rd,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0]  wb_rd,
  input  logic [rv_pkg::xlen-1:0]        wb_data,
  output logic                          redirect,
  output logic [rv_pkg::xlen-1:0]        redirect_pc,
  output logic                          ex_mem_mem_read, ex_mem_mem_write,
  output logic                          ex_mem_reg_write, ex_mem_halt_req,
  output logic [1:0]                    ex_mem_wb_src,
  output logic [rv_pkg::xlen-1:0]        ex_mem_result, ex_mem_store_data, ex_mem_pc4,
  output logic [rv_pkg::reg_addr_w-1:0]  ex_mem_rd
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a, op_b, alu_b, alu_y;
  logic            taken;

  // youngest producer wins
  function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] src,
                                          input logic [xlen-1:0]       reg_val);
    if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == src) begin
      return ex_mem_result;
    end else if (wb_we && wb_rd != '0 && wb_rd == src) begin
      return wb_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    op_a = fwd(id_ex_rs1, id_ex_rs1_data);
    op_b = fwd(id_ex_rs2, id_ex_rs2_data);
  end

  assign alu_b = id_ex_alu_src ? id_ex_imm : op_b;

  always_comb begin
    case (id_ex_alu_sel)
      alu_sub: alu_y = op_a - alu_b;
      alu_and: alu_y = op_a & alu_b;
      alu_or:  alu_y = op_a | alu_b;
      alu_slt: alu_y = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_y = op_a + alu_b;
    endcase
  end

  // not-taken is assumed, so any taken control transfer redirects
  assign taken       = id_ex_is_branch && ((op_a == op_b) != id_ex_branch_ne);
  assign redirect    = taken || id_ex_is_jal || id_ex_is_jalr;
  assign redirect_pc = id_ex_is_jalr ? {alu_y[xlen-1:1], 1'b0} : id_ex_pc + id_ex_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_mem_read  <= 1'b0;
      ex_mem_mem_write <= 1'b0;
      ex_mem_reg_write <= 1'b0;
      ex_mem_halt_req  <= 1'b0;
    end else if (!halted) begin
      ex_mem_mem_read  <= id_ex_mem_read;
      ex_mem_mem_write <= id_ex_mem_write;
      ex_mem_reg_write <= id_ex_reg_write;
      ex_mem_halt_req  <= id_ex_halt_req;
    end
  end

  always_ff @(posedge clk) begin
    if (!halted) begin
      ex_mem_wb_src     <= id_ex_wb_src;
      ex_mem_result     <= alu_y;
      ex_mem_store_data <= op_b; // forwarded rs2 for sw
      ex_mem_rd         <= id_ex_rd;
      ex_mem_pc4        <= id_ex_pc + 32'd4;
    end
  end

endmodule

//--- decode_stage.sv
// instruction decode, immediate generation and hazard detection
// ecall halt check with x17 forwarding
// ID/EX register and register file instance
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clk, reset, halted, redirect,
  input  rv_pkg::inst_t                 if_inst,
  input  logic [rv_pkg::xlen-1:0]        if_pc,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0]  wb_rd,
  input  logic [rv_pkg::xlen-1:0]        wb_data,
  input  logic [rv_pkg::reg_addr_w-1:0]  ex_mem_rd,
  input  logic                          ex_mem_reg_write,
  input  logic [rv_pkg::xlen-1:0]        ex_mem_result,
  input  logic [rv_pkg::reg_addr_w-1:0]  dbg_addr,
  output logic [rv_pkg::xlen-1:0]        dbg_data,
  output logic                          stall,
  output logic                          id_ex_alu_src, id_ex_mem_read, id_ex_mem_write,
  output logic                          id_ex_reg_write, id_ex_is_branch, id_ex_branch_ne,
  output logic                          id_ex_is_jal, id_ex_is_jalr, id_ex_halt_req,
  output logic [rv_pkg::alu_sel_w-1:0]   id_ex_alu_sel,
  output logic [1:0]                    id_ex_wb_src,
  output logic [rv_pkg::xlen-1:0]        id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc,
  output logic [rv_pkg::reg_addr_w-1:0]  id_ex_rs1, id_ex_rs2, id_ex_rd
);
  import rv_pkg::*;

  logic [6:0]            opcode;
  logic [6:0]            ctrl; // alu_src, mem_read, mem_write, reg_write, branch, jal, jalr
  logic [alu_sel_w-1:0]  alu_sel;
  logic [1:0]            wb_src;
  logic [xlen-1:0]       imm, rf_rs1_data, rf_rs2_data, x17_val;
  logic [reg_addr_w-1:0] rf_rs1;
  logic                  is_ecall, use_rs1, use_rs2, halt_req;

  assign opcode   = if_inst.r.opcode;
  assign is_ecall = (opcode == op_system) && (if_inst.i.funct3 == 3'b000) &&
                    (if_inst.i.imm12 == 12'd0);
  assign rf_rs1   = is_ecall ? halt_reg : if_inst.r.rs1; // ecall reads a7
  assign use_rs1  = (opcode != op_jal);
  assign use_rs2  = opcode inside {op_reg, op_store, op_branch};

  always_comb begin
    case (opcode)
      op_reg:    ctrl = 7'b0001000;
      op_imm:    ctrl = 7'b1001000;
      op_load:   ctrl = 7'b1101000;
      op_store:  ctrl = 7'b1010000;
      op_branch: ctrl = 7'b0000100;
      op_jal:    ctrl = 7'b0001010;
      op_jalr:   ctrl = 7'b1001001;
      default:   ctrl = 7'b0000000; // ecall and unknown
    endcase
  end

  always_comb begin
    case (if_inst.r.funct3)
      3'b010:  alu_sel = alu_slt;
      3'b110:  alu_sel = alu_or;
      3'b111:  alu_sel = alu_and;
      default: alu_sel = (opcode == op_reg && if_inst.r.funct7[5]) ? alu_sub : alu_add;
    endcase
    if (!(opcode inside {op_reg, op_imm})) alu_sel = alu_add; // address and jalr target
  end

  assign wb_src = (opcode == op_load) ? wb_mem :
                  ((opcode == op_jal || opcode == op_jalr) ? wb_pc4 : wb_alu);

  // b and j immediates are scattered over the i and s fields
  always_comb begin
    case (opcode)
      op_store:  imm = {{20{if_inst.s.imm_hi[6]}}, if_inst.s.imm_hi, if_inst.s.imm_lo};
      op_branch: imm = {{20{if_inst.s.imm_hi[6]}}, if_inst.s.imm_lo[0],
                        if_inst.s.imm_hi[5:0], if_inst.s.imm_lo[4:1], 1'b0};
      op_jal:    imm = {{12{if_inst.i.imm12[11]}}, if_inst.i.rs1, if_inst.i.funct3,
                        if_inst.i.imm12[0], if_inst.i.imm12[10:1], 1'b0};
      default:   imm = {{20{if_inst.i.imm12[11]}}, if_inst.i.imm12};
    endcase
  end

  // load-use, or ecall right behind a write to x17
  assign stall = (id_ex_rd != '0) &&
                 ((id_ex_mem_read && ((use_rs1 && id_ex_rd == rf_rs1) ||
                                      (use_rs2 && id_ex_rd == if_inst.r.rs2))) ||
                  (is_ecall && id_ex_reg_write && id_ex_rd == halt_reg));

  // writeback value already arrives through the regfile bypass
  assign x17_val  = (ex_mem_reg_write && ex_mem_rd == halt_reg) ? ex_mem_result : rf_rs1_data;
  assign halt_req = is_ecall && (x17_val == halt_code);

  register_file u_regs (
    .clk(clk), .reset(reset),
    .rs1(rf_rs1), .rs2(if_inst.r.rs2), .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
    .we(wb_we), .rd(wb_rd), .wd(wb_data),
    .dbg_addr(dbg_addr), .dbg_data(dbg_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      {id_ex_alu_src, id_ex_mem_read, id_ex_mem_write, id_ex_reg_write,
       id_ex_is_branch, id_ex_is_jal, id_ex_is_jalr, id_ex_halt_req} <= '0;
    end else if (!halted) begin
      {id_ex_alu_src, id_ex_mem_read, id_ex_mem_write, id_ex_reg_write,
       id_ex_is_branch, id_ex_is_jal, id_ex_is_jalr, id_ex_halt_req} <=
        (stall || redirect) ? 8'd0 : {ctrl, halt_req}; // bubble
    end
  end

  always_ff @(posedge clk) begin
    if (!halted) begin
      id_ex_alu_sel   <= alu_sel;
      id_ex_wb_src    <= wb_src;
      id_ex_branch_ne <= if_inst.r.funct3[0]; // bne
      id_ex_rs1_data  <= rf_rs1_data;
      id_ex_rs2_data  <= rf_rs2_data;
      id_ex_imm       <= imm;
      id_ex_pc        <= if_pc;
      id_ex_rs1       <= if_inst.r.rs1;
      id_ex_rs2       <= if_inst.r.rs2;
      id_ex_rd        <= if_inst.r.rd;
    end
  end

endmodule

//--- fetch_stage.sv
// program counter, instruction rom and IF/ID register
`timescale 1ns/1ps

module fetch_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall,
  input  logic                   redirect,
  input  logic [rv_pkg::xlen-1:0] redirect_pc,
  input  logic                   halted,
  output rv_pkg::inst_t          if_inst,
  output logic [rv_pkg::xlen-1:0] if_pc
);
  import rv_pkg::*;

  logic [xlen-1:0] pc;
  logic [31:0]     rom [0:imem_words-1];

  // words past the program read as nop
  initial begin
    for (int k = 0; k < imem_words; k++) begin
      rom[k] = nop_word;
    end
    $readmemh("prog.hex", rom);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= '0;
      if_inst <= nop_word;
    end else if (!halted) begin
      if (redirect) begin
        pc      <= redirect_pc;
        if_inst <= nop_word; // squash wrong-path fetch
      end else if (!stall) begin
        pc      <= pc + 32'd4;
        if_inst <= rom[pc[$clog2(imem_words)+1:2]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!halted && !redirect && !stall) if_pc <= pc;
  end

endmodule

//--- register_file.sv
// 32 x 32 register file
// two read ports with write bypass, one debug read port
`timescale 1ns/1ps

module register_file (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::reg_addr_w-1:0]  rs1, rs2,
  output logic [rv_pkg::xlen-1:0]        rs1_data, rs2_data,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0]  rd,
  input  logic [rv_pkg::xlen-1:0]        wd,
  input  logic [rv_pkg::reg_addr_w-1:0]  dbg_addr,
  output logic [rv_pkg::xlen-1:0]        dbg_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [0:(1 << reg_addr_w)-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < (1 << reg_addr_w); k++) begin
        regs[k] <= '0;
      end
    end else if (we && rd != '0) begin // x0 stays zero
      regs[rd] <= wd;
    end
  end

  // same-cycle write is visible to decode
  assign rs1_data = (we && rd != '0 && rd == rs1) ? wd : regs[rs1];
  assign rs2_data = (we && rd != '0 && rd == rs2) ? wd : regs[rs2];
  assign dbg_data = regs[dbg_addr];

endmodule

//--- rv_pkg.sv
// shared constants for the rv32i subset pipeline
// widths, opcodes, alu select and writeback codes, halt constants
// instruction word union with r, i and s views
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int imem_words = 64;
  localparam int dmem_words = 64;

  // base opcodes
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam int alu_sel_w = 3;
  localparam logic [alu_sel_w-1:0] alu_add = 3'd0;
  localparam logic [alu_sel_w-1:0] alu_sub = 3'd1;
  localparam logic [alu_sel_w-1:0] alu_and = 3'd2;
  localparam logic [alu_sel_w-1:0] alu_or  = 3'd3;
  localparam logic [alu_sel_w-1:0] alu_slt = 3'd4;

  localparam logic [1:0] wb_alu = 2'd0;
  localparam logic [1:0] wb_mem = 2'd1;
  localparam logic [1:0] wb_pc4 = 2'd2; // link value for jal/jalr

  // ecall halts when a7 holds 10
  localparam logic [reg_addr_w-1:0] halt_reg  = 5'd17;
  localparam logic [xlen-1:0]       halt_code = 32'd10;

  localparam logic [31:0] nop_word = 32'h0000_0013; // addi x0,x0,0

  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i;
    struct packed {
      logic [6:0]            imm_hi;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s;
  } inst_t;

endpackage
